/* core_pipe.f */
+incdir+common
common/core_pkg.sv
common/hazard_if.sv
hdl/core_if.sv
id/mips_decoder.sv
id/regfile.sv
id/core_id.sv
hdl/core_ex.sv
hdl/hazard_unit.sv
hdl/core_pipe.sv
dv/core_pipe_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the core_pipe testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f core_pipe.f --top-module core_pipe_tb -o core_pipe_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/core_pipe_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Regression passed$"; then
    exit 0
fi
exit 1

/* dv/core_pipe_tb.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_pipe_tb;
    typedef struct packed {
        logic        we;
        logic        rsv;
        logic        ovf;
        logic [4:0]  regnum;
        logic [63:0] data;
    } wb_rec_t;

    localparam int M_NOP = 0;
    localparam int M_RAND = 1;
    localparam int M_FWD = 2;
    localparam int M_BRANCH = 3;
    localparam logic [5:0] R_FUNCTS [9] = '{6'h2c, 6'h2d, 6'h2e, 6'h2f, 6'h24, 6'h25,
                                            6'h26, 6'h2a, 6'h2b};
    localparam logic [5:0] I_OPS [6] = '{6'h19, 6'h0c, 6'h0d, 6'h0e, 6'h0a, 6'h0f};

    logic                  clock;
    logic                  reset;
    logic [31:0]           inst;
    logic [`CORE_XLEN-1:0] pc;
    logic                  hold;
    logic                  wb_write_enable;
    logic [4:0]            wb_regnum;
    logic [`CORE_XLEN-1:0] wb_data;
    logic                  redirect;
    logic [`CORE_XLEN-1:0] redirect_pc;
    logic                  reserved_inst;
    logic                  overflow;

    logic [63:0] model_regs [32];
    wb_rec_t     exp_q [$];
    logic [31:0] script [$];
    int          br_stage;      // 1 after a taken branch is fetched, 2 while it redirects.
    logic [63:0] br_target;
    int          mode;
    int          errors;
    int          ntests;
    string       tname;

    core_pipe u_core_pipe (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        #200000;
        $display("timeout: simulation did not finish in time");
        $display("Regression failed");
        $finish;
    end

    function automatic logic [31:0] make_r(input logic [5:0] funct, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] make_i(input logic [5:0] op, input logic [4:0] rt,
                                           input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] gen_inst();
        logic [4:0] s;
        logic [4:0] t;
        logic [4:0] d;
        int         hi;
        int         off;
        hi = (mode == M_RAND) ? 31 : 3;
        s = 5'($urandom_range(hi, 0));
        t = 5'($urandom_range(hi, 0));
        d = 5'($urandom_range(hi, 0));
        off = int'($urandom_range(12, 0)) - 4;
        if (script.size() != 0) begin
            return script.pop_front();
        end else if (mode == M_NOP) begin
            return 32'h0;
        end else if (mode == M_BRANCH && $urandom_range(3, 0) == 0) begin
            case ($urandom_range(2, 0))
                0:       return make_i(6'h04, t, s, 16'(off));
                1:       return make_i(6'h05, t, s, 16'(off));
                default: return {6'h32, 26'(off)};
            endcase
        end else if ($urandom_range(1, 0) == 0) begin
            return make_r(R_FUNCTS[$urandom_range(8, 0)], d, s, t);
        end
        return make_i(I_OPS[$urandom_range(5, 0)], t, s, 16'($urandom));
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model, one instruction at a time
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic issue_model(input logic [31:0] i, input logic [63:0] ipc);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] se;
        logic [63:0] ze;
        logic [63:0] res;
        logic [4:0]  dst;
        logic        we;
        logic        ovf;
        logic        rsv;
        a = model_regs[i[25:21]];
        b = model_regs[i[20:16]];
        se = {{48{i[15]}}, i[15:0]};
        ze = {48'h0, i[15:0]};
        dst = i[20:16];
        we = 1'b1;
        ovf = 1'b0;
        rsv = 1'b0;
        res = '0;
        case (i[31:26])
            6'h00: begin
                dst = i[15:11];
                case (i[5:0])
                    6'h2c: begin
                        res = a + b;
                        ovf = (a[63] == b[63]) && (res[63] != a[63]);
                    end
                    6'h2d: res = a + b;
                    6'h2e: begin
                        res = a - b;
                        ovf = (a[63] != b[63]) && (res[63] != a[63]);
                    end
                    6'h2f: res = a - b;
                    6'h24: res = a & b;
                    6'h25: res = a | b;
                    6'h26: res = a ^ b;
                    6'h2a: res = {63'h0, $signed(a) < $signed(b)};
                    6'h2b: res = {63'h0, a < b};
                    default: begin
                        we = 1'b0;
                        rsv = (i != 32'h0);
                    end
                endcase
            end
            6'h19: res = a + se;
            6'h0c: res = a & ze;
            6'h0d: res = a | ze;
            6'h0e: res = a ^ ze;
            6'h0a: res = {63'h0, $signed(a) < $signed(se)};
            6'h0f: res = {{32{i[15]}}, i[15:0], 16'h0000};
            6'h04, 6'h05, 6'h32: begin
                we = 1'b0;
                if (i[31:26] == 6'h32) begin
                    br_target = ipc + {{36{i[25]}}, i[25:0], 2'b00};
                end else begin
                    br_target = ipc + {{46{i[15]}}, i[15:0], 2'b00};
                end
                if (i[31:26] == 6'h32 || ((i[31:26] == 6'h04) == (a == b))) begin
                    br_stage = 1;
                end
            end
            default: begin
                we = 1'b0;
                rsv = 1'b1;
            end
        endcase
        if (we || rsv || ovf) begin
            exp_q.push_back('{we && !ovf, rsv, ovf, dst, res});
        end
        if (we && !ovf && dst != 5'd0) begin
            model_regs[dst] = res;
        end
    endtask

    // one clock of fetch; the testbench is the instruction memory.
    task automatic step(input int hold_pct);
        logic        squash;
        logic        redir_edge;
        logic        taken_in;
        logic [63:0] next_pc;
        @(posedge clock);
        squash = (br_stage != 0);
        redir_edge = (br_stage == 2);
        br_stage = (br_stage == 1) ? 2 : 0;
        taken_in = !hold;
        next_pc = redir_edge ? br_target : pc + 64'd4;
        if (taken_in && !squash) begin
            issue_model(inst, pc);
        end
        #2;
        if (taken_in) begin
            pc = next_pc;
            inst = gen_inst();
        end
        hold = (br_stage == 0) && (int'($urandom_range(99, 0)) < hold_pct);
    endtask

    task automatic run_test(input string name, input int m, input int cycles,
                            input int hold_pct);
        int err0;
        int n;
        tname = name;
        mode = m;
        err0 = errors;
        repeat (cycles) step(hold_pct);
        mode = M_NOP;
        n = 0;
        while ((exp_q.size() != 0 || br_stage != 0 || hold) && n < 50) begin
            step(0);
            n++;
        end
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%s: %0d expected writebacks never appeared", name, exp_q.size());
        end
        exp_q.delete();
        ntests++;
        $display("test %-10s %s (%0d errors)", name,
                 (errors == err0) ? "ok" : "FAILED", errors - err0);
    endtask

    always @(negedge clock) begin : check_outputs
        wb_rec_t e;
        wb_rec_t got;
        if (reset) begin
            assert (!wb_write_enable && !redirect && !reserved_inst && !overflow) else begin
                errors++;
                $display("%s: outputs active during reset", tname);
            end
        end else begin
            assert (redirect == (br_stage == 2)) else begin
                errors++;
                $display("Fail %s redirect expected %0b actual %0b", tname, br_stage == 2,
                         redirect);
            end
            if (br_stage == 2) begin
                assert (redirect_pc == br_target) else begin
                    errors++;
                    $display("Fail %s redirect_pc expected %h actual %h", tname, br_target,
                             redirect_pc);
                end
            end
            if (wb_write_enable || reserved_inst || overflow) begin
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("%s: writeback seen with nothing expected", tname);
                end
                if (exp_q.size() != 0) begin
                    e = exp_q.pop_front();
                    got = '{wb_write_enable, reserved_inst, overflow,
                            e.we ? wb_regnum : e.regnum, e.we ? wb_data : e.data};
                    assert (got == e) else begin
                        errors++;
                        $display("Fail %s expected %h actual %h", tname, e, got);
                    end
                end
            end
        end
    end

    initial begin
        void'($urandom(32'hbb5a_453c));
        reset = 1'b1;
        hold = 1'b0;
        inst = 32'h0;
        pc = '0;
        model_regs = '{default: '0};
        br_stage = 0;
        br_target = '0;
        mode = M_NOP;
        errors = 0;
        ntests = 0;
        tname = "reset";
        repeat (2) @(posedge clock);
        #2 reset = 1'b0;
        run_test("reset", M_NOP, 4, 0);

        // slt edges on all ones, then lui.
        script.push_back(make_i(6'h19, 5'd1, 5'd0, 16'hffff));
        script.push_back(make_r(6'h2b, 5'd2, 5'd0, 5'd1));
        script.push_back(make_r(6'h2a, 5'd3, 5'd0, 5'd1));
        script.push_back(make_i(6'h0a, 5'd4, 5'd1, 16'h0000));
        script.push_back(make_i(6'h0f, 5'd5, 5'd0, 16'h8001));
        run_test("arith", M_RAND, 300, 0);
        run_test("forward", M_FWD, 300, 0);
        run_test("branch", M_BRANCH, 400, 0);
        run_test("hold", M_FWD, 300, 30);

        script.push_back(32'hfc00_0000);
        script.push_back(make_r(6'h3f, 5'd1, 5'd2, 5'd3));
        script.push_back(make_i(6'h0f, 5'd1, 5'd0, 16'h4000));
        repeat (32) script.push_back(make_r(6'h2d, 5'd1, 5'd1, 5'd1));  // up to 2**62.
        script.push_back(make_r(6'h2c, 5'd2, 5'd1, 5'd1));
        script.push_back(make_r(6'h2d, 5'd6, 5'd2, 5'd0));   // reads r2 behind the dropped write.
        script.push_back(make_r(6'h2d, 5'd3, 5'd1, 5'd1));
        script.push_back(make_r(6'h2e, 5'd4, 5'd0, 5'd3));
        script.push_back(make_r(6'h2a, 5'd5, 5'd1, 5'd3));   // slt across overflow.
        script.push_back(make_r(6'h2a, 5'd7, 5'd3, 5'd1));
        run_test("except", M_NOP, 45, 0);

        $display("tests run %0d, errors %0d", ntests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end
endmodule

/* hdl/core_pipe.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_pipe (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [31:0]           inst,
    input  logic [`CORE_XLEN-1:0] pc,
    input  logic                  hold,
    output logic                  wb_write_enable,
    output logic [4:0]            wb_regnum,
    output logic [`CORE_XLEN-1:0] wb_data,
    output logic                  redirect,
    output logic [`CORE_XLEN-1:0] redirect_pc,
    output logic                  reserved_inst,
    output logic                  overflow
);
    import core_pkg::*;

    IF_regs_t  IF_regs;
    ID_regs_t  ID_regs;
    MEM_regs_t MEM_regs;
    xlen_t     EX_out;
    logic      branch_taken;

    hazard_if hz ();

    core_if u_if (
        .clock   (clock),
        .reset   (reset),
        .inst    (inst),
        .pc      (pc),
        .hz      (hz.stage),
        .IF_regs (IF_regs)
    );

    core_id u_id (
        .clock    (clock),
        .reset    (reset),
        .IF_regs  (IF_regs),
        .hz       (hz.stage),
        .MEM_regs (MEM_regs),
        .EX_out   (EX_out),
        .ID_regs  (ID_regs)
    );

    core_ex u_ex (
        .clock        (clock),
        .reset        (reset),
        .ID_regs      (ID_regs),
        .EX_out       (EX_out),
        .branch_taken (branch_taken),
        .MEM_regs     (MEM_regs)
    );

    hazard_unit u_hazard (
        .IF_regs      (IF_regs),
        .ID_regs      (ID_regs),
        .MEM_regs     (MEM_regs),
        .hold         (hold),
        .branch_taken (branch_taken),
        .hz           (hz.unit)
    );

    assign wb_write_enable = MEM_regs.write_enable;
    assign wb_regnum       = MEM_regs.W_regnum;
    assign wb_data         = MEM_regs.W_data;
    assign reserved_inst   = MEM_regs.reserved_inst;
    assign overflow        = MEM_regs.overflow;
    assign redirect        = branch_taken;
    assign redirect_pc     = ID_regs.pc_branch;
endmodule

/* hdl/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    input  core_pkg::IF_regs_t  IF_regs,
    input  core_pkg::ID_regs_t  ID_regs,
    input  core_pkg::MEM_regs_t MEM_regs,
    input  logic                hold,
    input  logic                branch_taken,
    hazard_if.unit              hz
);
    import core_pkg::*;

    regnum_t rs;
    regnum_t rt;
    logic    ex_writes;

    assign rs        = IF_regs.inst[25:21];
    assign rt        = IF_regs.inst[20:16];
    assign ex_writes = ID_regs.write_enable & ~ID_regs.overflow & (ID_regs.W_regnum != '0);

    // execute result wins over the writeback record.
    always_comb begin
        hz.forward_a = FWD_RF;
        hz.forward_b = FWD_RF;
        if (ex_writes && ID_regs.W_regnum == rs) begin
            hz.forward_a = FWD_EX;
        end else if (MEM_regs.write_enable && MEM_regs.W_regnum != '0 &&
                     MEM_regs.W_regnum == rs) begin
            hz.forward_a = FWD_MEM;
        end
        if (ex_writes && ID_regs.W_regnum == rt) begin
            hz.forward_b = FWD_EX;
        end else if (MEM_regs.write_enable && MEM_regs.W_regnum != '0 &&
                     MEM_regs.W_regnum == rt) begin
            hz.forward_b = FWD_MEM;
        end
    end

    assign hz.stall = hold;
    assign hz.flush = branch_taken;
endmodule

/* hdl/core_ex.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_ex (
    input  logic                  clock,
    input  logic                  reset,
    input  core_pkg::ID_regs_t    ID_regs,
    output logic [`CORE_XLEN-1:0] EX_out,
    output logic                  branch_taken,
    output core_pkg::MEM_regs_t   MEM_regs
);
    import core_pkg::*;

    xlen_t logic_b;
    xlen_t logic_out;
    xlen_t lui_val;

    // immediate logic ops take the zero-extended field.
    assign logic_b = (ID_regs.inst[31:26] == 6'h00) ? ID_regs.B_data
                   : {{(`CORE_XLEN-16){1'b0}}, ID_regs.inst[15:0]};
    assign lui_val = {{(`CORE_XLEN-32){ID_regs.inst[15]}}, ID_regs.inst[15:0], 16'h0000};

    always_comb begin
        case (ID_regs.alu_op[1:0])
            2'b00:   logic_out = ID_regs.A_data & logic_b;
            2'b01:   logic_out = ID_regs.A_data | logic_b;
            default: logic_out = ID_regs.A_data ^ logic_b;
        endcase
    end

    always_comb begin
        if (ID_regs.lui) begin
            EX_out = lui_val;
        end else if (ID_regs.slt_type == SLT_SIGNED) begin
            EX_out = xlen_t'(ID_regs.negative ^ ID_regs.overflow);
        end else if (ID_regs.slt_type == SLT_UNSIGNED) begin
            EX_out = xlen_t'(ID_regs.borrow_out);
        end else if (ID_regs.alu_op[2]) begin
            EX_out = logic_out;
        end else begin
            EX_out = ID_regs.AU_out;
        end
    end

    always_comb begin
        case (ID_regs.control_type)
            CT_BEQ:  branch_taken = ID_regs.zero;
            CT_BNE:  branch_taken = ~ID_regs.zero;
            CT_BC:   branch_taken = 1'b1;
            default: branch_taken = 1'b0;
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            MEM_regs <= '0;
        end else begin
            MEM_regs.write_enable  <= ID_regs.write_enable & ~ID_regs.overflow;
            MEM_regs.W_regnum      <= ID_regs.W_regnum;
            MEM_regs.W_data        <= EX_out;
            MEM_regs.reserved_inst <= ID_regs.reserved_inst;
            MEM_regs.overflow      <= ID_regs.overflow;
        end
    end
endmodule

/* id/core_id.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_id (
    input  logic                  clock,
    input  logic                  reset,
    input  core_pkg::IF_regs_t    IF_regs,
    hazard_if.stage               hz,
    input  core_pkg::MEM_regs_t   MEM_regs,
    input  logic [`CORE_XLEN-1:0] EX_out,
    output core_pkg::ID_regs_t    ID_regs
);
    import core_pkg::*;

    alu_op_t       alu_op;
    alu_src2_t     alu_src2;
    rd_src_t       rd_src;
    control_type_t control_type;
    slt_type_t     slt_type;
    logic          write_enable;
    logic          lui;
    logic          reserved_inst;
    logic          ignore_overflow;

    xlen_t               rf_a;
    xlen_t               rf_b;
    xlen_t               fwd_a;
    xlen_t               fwd_b;
    xlen_t               b_in;
    xlen_t               au_b;
    xlen_t               au_out;
    xlen_t               br_off;
    logic [`CORE_XLEN:0] au_sum;
    logic                au_overflow;
    logic                au_borrow;
    ID_regs_t            id_next;

    function automatic xlen_t fwd_pick(input forward_type_t sel, input xlen_t rf_val,
                                       input xlen_t ex_val, input xlen_t mem_val);
        case (sel)
            FWD_EX:  return ex_val;
            FWD_MEM: return mem_val;
            default: return rf_val;
        endcase
    endfunction

    mips_decoder u_decoder (
        .inst            (IF_regs.inst),
        .alu_op          (alu_op),
        .alu_src2        (alu_src2),
        .rd_src          (rd_src),
        .write_enable    (write_enable),
        .control_type    (control_type),
        .slt_type        (slt_type),
        .lui             (lui),
        .reserved_inst   (reserved_inst),
        .ignore_overflow (ignore_overflow)
    );

    regfile u_regfile (
        .clock   (clock),
        .reset   (reset),
        .ra      (IF_regs.inst[25:21]),
        .rb      (IF_regs.inst[20:16]),
        .rdata_a (rf_a),
        .rdata_b (rf_b),
        .wa      (MEM_regs.W_regnum),
        .wdata   (MEM_regs.W_data),
        .we      (MEM_regs.write_enable)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operands and early add/subtract
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign fwd_a = fwd_pick(hz.forward_a, rf_a, EX_out, MEM_regs.W_data);
    assign fwd_b = fwd_pick(hz.forward_b, rf_b, EX_out, MEM_regs.W_data);

    always_comb begin
        case (alu_src2)
            SRC2_SEXT: b_in = {{(`CORE_XLEN-16){IF_regs.inst[15]}}, IF_regs.inst[15:0]};
            SRC2_ZEXT: b_in = {{(`CORE_XLEN-16){1'b0}}, IF_regs.inst[15:0]};
            default:   b_in = fwd_b;
        endcase
    end

    assign au_b        = alu_op[0] ? ~b_in : b_in;      // subtract as a + ~b + 1.
    assign au_sum      = {1'b0, fwd_a} + {1'b0, au_b} + (`CORE_XLEN+1)'(alu_op[0]);
    assign au_out      = au_sum[`CORE_XLEN-1:0];
    assign au_borrow   = alu_op[0] & ~au_sum[`CORE_XLEN];
    assign au_overflow = (fwd_a[`CORE_XLEN-1] == au_b[`CORE_XLEN-1]) &&
                         (au_out[`CORE_XLEN-1] != fwd_a[`CORE_XLEN-1]);

    // word offset, 26 bits for bc.
    assign br_off = (control_type == CT_BC)
                  ? {{(`CORE_XLEN-28){IF_regs.inst[25]}}, IF_regs.inst[25:0], 2'b00}
                  : {{(`CORE_XLEN-18){IF_regs.inst[15]}}, IF_regs.inst[15:0], 2'b00};

    always_comb begin
        id_next.inst          = IF_regs.inst;
        id_next.pc4           = IF_regs.pc4;
        id_next.pc_branch     = IF_regs.pc + br_off;
        id_next.A_data        = fwd_a;
        id_next.B_data        = fwd_b;                  // raw register value.
        id_next.AU_out        = au_out;
        id_next.zero          = (au_out == '0);
        id_next.borrow_out    = au_borrow;
        id_next.overflow      = au_overflow & ~ignore_overflow;
        // signed less-than rides on negative, overflow being masked for slt.
        id_next.negative      = (slt_type == SLT_SIGNED) ? au_out[`CORE_XLEN-1] ^ au_overflow
                                                         : au_out[`CORE_XLEN-1];
        id_next.alu_op        = alu_op;
        id_next.slt_type      = slt_type;
        id_next.control_type  = control_type;
        id_next.lui           = lui;
        id_next.W_regnum      = (rd_src == RD_RT) ? IF_regs.inst[20:16] : IF_regs.inst[15:11];
        id_next.write_enable  = write_enable;
        id_next.reserved_inst = reserved_inst;
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            ID_regs <= '0;
        end else if (hz.stall || hz.flush) begin
            ID_regs <= '0;                              // bubble.
        end else begin
            ID_regs <= id_next;
        end
    end
endmodule

/* id/regfile.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module regfile (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [4:0]            ra,
    input  logic [4:0]            rb,
    output logic [`CORE_XLEN-1:0] rdata_a,
    output logic [`CORE_XLEN-1:0] rdata_b,
    input  logic [4:0]            wa,
    input  logic [`CORE_XLEN-1:0] wdata,
    input  logic                  we
);
    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

    // same-cycle write is not visible here.
    assign rdata_a = regs[ra];
    assign rdata_b = regs[rb];

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wdata;
        end
    end
endmodule

/* id/mips_decoder.sv */
`timescale 1ns/1ps

module mips_decoder (
    input  logic [31:0]                inst,
    output core_pkg::alu_op_t          alu_op,
    output core_pkg::alu_src2_t        alu_src2,
    output core_pkg::rd_src_t          rd_src,
    output logic                       write_enable,
    output core_pkg::control_type_t    control_type,
    output core_pkg::slt_type_t        slt_type,
    output logic                       lui,
    output logic                       reserved_inst,
    output logic                       ignore_overflow
);
    import core_pkg::*;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_DADDIU  = 6'h19;
    localparam logic [5:0] OP_BC      = 6'h32;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];

    always_comb begin
        alu_op          = ALU_ADD;
        alu_src2        = SRC2_REG;
        rd_src          = RD_RD;
        write_enable    = 1'b1;
        control_type    = CT_NONE;
        slt_type        = SLT_NONE;
        lui             = 1'b0;
        reserved_inst   = 1'b0;
        ignore_overflow = 1'b1;
        if (opcode != OP_SPECIAL) begin
            rd_src = RD_RT;
        end
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    6'h2c: ignore_overflow = 1'b0;                      // dadd.
                    6'h2d: alu_op = ALU_ADD;                            // daddu.
                    6'h2e: begin                                        // dsub.
                        alu_op          = ALU_SUB;
                        ignore_overflow = 1'b0;
                    end
                    6'h2f: alu_op = ALU_SUB;                            // dsubu.
                    6'h24: alu_op = ALU_AND;
                    6'h25: alu_op = ALU_OR;
                    6'h26: alu_op = ALU_XOR;
                    6'h2a: begin
                        alu_op   = ALU_SUB;
                        slt_type = SLT_SIGNED;
                    end
                    6'h2b: begin
                        alu_op   = ALU_SUB;
                        slt_type = SLT_UNSIGNED;
                    end
                    default: begin
                        write_enable  = 1'b0;
                        reserved_inst = (inst != 32'h0);                // all zero is the nop.
                    end
                endcase
            end
            OP_DADDIU: alu_src2 = SRC2_SEXT;
            OP_ANDI: begin
                alu_op   = ALU_AND;
                alu_src2 = SRC2_ZEXT;
            end
            OP_ORI: begin
                alu_op   = ALU_OR;
                alu_src2 = SRC2_ZEXT;
            end
            OP_XORI: begin
                alu_op   = ALU_XOR;
                alu_src2 = SRC2_ZEXT;
            end
            OP_SLTI: begin
                alu_op   = ALU_SUB;
                alu_src2 = SRC2_SEXT;
                slt_type = SLT_SIGNED;
            end
            OP_LUI: lui = 1'b1;
            OP_BEQ, OP_BNE, OP_BC: begin
                alu_op       = ALU_SUB;                                 // zero flag compares.
                write_enable = 1'b0;
                control_type = (opcode == OP_BEQ) ? CT_BEQ :
                               (opcode == OP_BNE) ? CT_BNE : CT_BC;
            end
            default: begin
                write_enable  = 1'b0;
                reserved_inst = 1'b1;
            end
        endcase
    end
endmodule

/* hdl/core_if.sv */
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_if (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [31:0]           inst,
    input  logic [`CORE_XLEN-1:0] pc,
    hazard_if.stage               hz,
    output core_pkg::IF_regs_t    IF_regs
);
    import core_pkg::*;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            IF_regs <= '0;
        end else if (hz.flush) begin
            IF_regs <= '0;              // squash on taken branch.
        end else if (!hz.stall) begin
            IF_regs.inst <= inst;
            IF_regs.pc   <= pc;
            IF_regs.pc4  <= pc + xlen_t'(4);
        end
    end
endmodule

/* common/hazard_if.sv */
`timescale 1ns/1ps

interface hazard_if;
    import core_pkg::*;

    forward_type_t forward_a;   // rs source.
    forward_type_t forward_b;   // rt source.
    logic          stall;
    logic          flush;

    modport unit (output forward_a, forward_b, stall, flush);
    modport stage (input forward_a, forward_b, stall, flush);
endinterface

/* common/core_pkg.sv */
`include "core_cfg.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0]          xlen_t;
    typedef logic [$clog2(`CORE_NREGS)-1:0] regnum_t;

    typedef enum logic [1:0] {
        FWD_RF  = 2'd0,
        FWD_EX  = 2'd1,
        FWD_MEM = 2'd2
    } forward_type_t;

    // bit 2 picks the logic unit, bit 0 is subtract.
    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b100,
        ALU_OR  = 3'b101,
        ALU_XOR = 3'b110
    } alu_op_t;

    typedef enum logic [1:0] {
        CT_NONE,
        CT_BEQ,
        CT_BNE,
        CT_BC
    } control_type_t;

    typedef enum logic [1:0] {
        SLT_NONE,
        SLT_SIGNED,
        SLT_UNSIGNED
    } slt_type_t;

    typedef enum logic [1:0] {
        SRC2_REG,
        SRC2_SEXT,
        SRC2_ZEXT
    } alu_src2_t;

    typedef enum logic {
        RD_RD,
        RD_RT
    } rd_src_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline records
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [31:0] inst;
        xlen_t       pc;
        xlen_t       pc4;
    } IF_regs_t;

    typedef struct packed {
        logic [31:0]   inst;
        xlen_t         pc4;
        xlen_t         pc_branch;
        xlen_t         A_data;
        xlen_t         B_data;
        xlen_t         AU_out;
        logic          zero;
        logic          negative;
        logic          borrow_out;
        logic          overflow;
        alu_op_t       alu_op;
        slt_type_t     slt_type;
        control_type_t control_type;
        logic          lui;
        regnum_t       W_regnum;
        logic          write_enable;
        logic          reserved_inst;
    } ID_regs_t;

    typedef struct packed {
        logic    write_enable;
        regnum_t W_regnum;
        xlen_t   W_data;
        logic    reserved_inst;
        logic    overflow;
    } MEM_regs_t;

endpackage

/* common/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data and pc width.
`define CORE_XLEN  64

// architectural registers.
`define CORE_NREGS 32

`endif
